// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_fetch_frontend
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/bp_if.sv
verilog/fetch_cfg.sv
verilog/branch_predictor.sv
verilog/fetch_unit.sv
verilog/fetch_frontend.sv
test/imem_model.sv
test/tb_fetch_frontend.sv

// File: test/imem_model.sv
/*
 * Behavioral instruction memory
 * Takes one request at a time and answers it 1 to MAX_LAT cycles later
 * from a program array with B-type words at two chosen addresses
 */

module imem_model #(
	parameter int          MAX_LAT = 6,
	parameter logic [31:0] BR_A    = 32'h0000_0040,
	parameter logic [31:0] BR_B    = 32'h0000_0208
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        i_en,
	input  logic [31:0] i_addr,
	output logic        o_rdy,
	output logic        o_vld,
	output logic [31:0] o_data
);

	localparam int WORDS = 1024;

	logic [31:0] mem [WORDS];
	logic        busy;
	logic [31:0] req_addr;
	int          delay;

	// Word mixed from the full byte address, OP-IMM opcode unless a branch
	function automatic logic [31:0] fill_word(input logic [31:0] a);
		logic [31:0] h;
		h = (a * 32'h9e37_79b1) ^ (a >> 7) ^ a;
		if (a == BR_A || a == BR_B)
			return {h[31:7], 7'b1100011};
		return {h[31:7], 7'b0010011};
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = fill_word(32'(i) << 2);
	end

	// Ready whenever no request is open
	assign o_rdy = !busy;

	always @(posedge clk) begin
		if (rst_n) begin
			busy  <= 1'b0;
			o_vld <= 1'b0;
			delay <= 0;
		end else begin
			o_vld <= 1'b0;
			if (i_en && !busy) begin
				busy     <= 1'b1;
				req_addr <= i_addr;
				// Extra wait states beyond the one-cycle minimum
				delay    <= $urandom_range(MAX_LAT - 1, 0);
			end else if (busy) begin
				if (delay == 0) begin
					busy   <= 1'b0;
					o_vld  <= 1'b1;
					o_data <= mem[req_addr[11:2]];
				end else begin
					delay <= delay - 1;
				end
			end
		end
	end

endmodule

// File: test/tb_fetch_frontend.sv
/*
 * Fetch front end testbench
 * Sequential fetch, predictor training, redirect, trap, prediction
 * disable and random stalls, checked against a reference model
 */

`include "fetch_config.svh"

module tb_fetch_frontend;

	localparam int          MAX_LAT      = 6;
	localparam int          RESET_CYCLES = 16;
	localparam int          STALL_CYCLES = 200;
	localparam int          TOTAL_BEATS  = 48;
	// Each beat costs a request, the full delay and the delivery
	localparam int          TIMEOUT      = RESET_CYCLES + STALL_CYCLES
		+ TOTAL_BEATS * (MAX_LAT + 3) + 400;
	localparam int          BP_ENTRIES   = 1 << `BP_IDX_W;
	localparam logic [31:0] SEED         = 32'hfc7783f5;
	localparam logic [31:0] BR_A         = 32'h0000_0040;
	localparam logic [31:0] BR_B         = 32'h0000_0208;
	localparam logic [31:0] BR_TARGET    = 32'h0000_0200;
	localparam logic [31:0] LOOP_PC      = 32'h0000_0030;
	localparam logic [31:0] BOJ_PC       = 32'h0000_0180;

	logic                 clk;
	logic                 rst_n;
	logic                 imem_rdy;
	logic                 imem_en;
	fetch_pkg::addr_t     iaddr;
	logic                 imem_vld;
	fetch_pkg::instr_t    inst;
	logic                 boj;
	fetch_pkg::addr_t     boj_pc;
	logic                 trap;
	logic                 res_valid;
	fetch_pkg::addr_t     res_pc;
	logic                 res_taken;
	fetch_pkg::addr_t     res_target;
	logic                 stall;
	logic                 cfg_we;
	fetch_pkg::cfg_addr_t cfg_addr;
	fetch_pkg::addr_t     cfg_wdata;
	fetch_pkg::addr_t     cfg_rdata;
	logic                 valid;
	fetch_pkg::addr_t     pc;
	fetch_pkg::instr_t    instr;
	logic                 prediction;

	// Reference predictor table and expected state
	logic                 m_valid  [BP_ENTRIES];
	fetch_pkg::bp_tag_t   m_tag    [BP_ENTRIES];
	fetch_pkg::ctr_t      m_ctr    [BP_ENTRIES];
	fetch_pkg::addr_t     m_target [BP_ENTRIES];
	logic                 exp_pred_en;
	fetch_pkg::addr_t     exp_trap_vec;
	fetch_pkg::addr_t     exp_pc;
	int                   exp_redir;
	int                   beat_cnt;
	int                   cycle_cnt = 0;
	string                test_name;

	fetch_frontend u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_imem_rdy   (imem_rdy),
		.o_imem_en    (imem_en),
		.o_iaddr      (iaddr),
		.i_imem_vld   (imem_vld),
		.i_inst       (inst),
		.i_boj        (boj),
		.i_boj_pc     (boj_pc),
		.i_trap       (trap),
		.i_res_valid  (res_valid),
		.i_res_pc     (res_pc),
		.i_res_taken  (res_taken),
		.i_res_target (res_target),
		.i_stall      (stall),
		.i_cfg_we     (cfg_we),
		.i_cfg_addr   (cfg_addr),
		.i_cfg_wdata  (cfg_wdata),
		.o_cfg_rdata  (cfg_rdata),
		.o_valid      (valid),
		.o_pc         (pc),
		.o_instr      (instr),
		.o_prediction (prediction)
	);

	imem_model #(.MAX_LAT(MAX_LAT), .BR_A(BR_A), .BR_B(BR_B)) u_imem (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_en   (imem_en),
		.i_addr (iaddr),
		.o_rdy  (imem_rdy),
		.o_vld  (imem_vld),
		.o_data (inst)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string field, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		assert (act_v === exp_v) else begin
			$display("FAIL %s %s: expected %h, actual %h", test_name, field, exp_v, act_v);
			$display("sim failed");
			$fatal(1, "mismatch");
		end
	endtask

	// Taken only for a branch word on a valid tag match with counter at 2 or more
	function automatic logic ref_predict(input fetch_pkg::addr_t a, input fetch_pkg::instr_t w);
		fetch_pkg::bp_idx_t idx;
		logic               hit;
		idx = a[`BP_IDX_W+1:2];
		hit = m_valid[idx] && (m_tag[idx] == a[31:`BP_IDX_W+2]);
		if (!exp_pred_en || w[6:0] != `OPC_BRANCH || !hit)
			return 1'b0;
		return m_ctr[idx] >= 2'd2;
	endfunction

	function automatic fetch_pkg::addr_t ref_next_pc(input fetch_pkg::addr_t a,
		input fetch_pkg::instr_t w);
		if (ref_predict(a, w))
			return m_target[a[`BP_IDX_W+1:2]];
		return a + 32'd4;
	endfunction

	task automatic model_update(input fetch_pkg::addr_t a, input logic taken,
		input fetch_pkg::addr_t t);
		fetch_pkg::bp_idx_t idx;
		idx = a[`BP_IDX_W+1:2];
		if (!m_valid[idx] || m_tag[idx] != a[31:`BP_IDX_W+2]) begin
			m_valid[idx]  = 1'b1;
			m_tag[idx]    = a[31:`BP_IDX_W+2];
			m_ctr[idx]    = taken ? 2'd2 : 2'd1;
			m_target[idx] = t;
		end else if (taken) begin
			if (m_ctr[idx] != 2'd3)
				m_ctr[idx] = m_ctr[idx] + 2'd1;
			m_target[idx] = t;
		end else if (m_ctr[idx] != 2'd0) begin
			m_ctr[idx] = m_ctr[idx] - 2'd1;
		end
	endtask

	// Beat checker, compares every delivery with the reference
	always @(posedge clk) begin
		fetch_pkg::instr_t exp_word;
		logic              exp_pred;
		if (!rst_n) begin
			assert (!(stall && imem_en)) else begin
				$display("Memory request issued while stalled, address %h", iaddr);
				$display("sim failed");
				$fatal(1, "request during stall");
			end
			if (valid) begin
				exp_word = u_imem.mem[exp_pc[11:2]];
				exp_pred = ref_predict(exp_pc, exp_word);
				check_value("pc", exp_pc, pc);
				check_value("word", exp_word, instr);
				check_value("prediction", {31'd0, exp_pred}, {31'd0, prediction});
				exp_pc = ref_next_pc(exp_pc, exp_word);
				beat_cnt++;
			end
			// Each request goes to the PC of the next expected beat
			if (imem_en)
				check_value("iaddr", exp_pc, iaddr);
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("Timeout in %s: fetch stopped delivering after %0d cycles",
				test_name, cycle_cnt);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

	task automatic wait_beats(input int n);
		int target;
		target = beat_cnt + n;
		while (beat_cnt < target)
			@(negedge clk);
	endtask

	// Hit the delay of the request just issued, so its response is dropped
	task automatic issue_redirect(input logic do_trap, input logic do_boj,
		input fetch_pkg::addr_t t);
		@(posedge clk);
		while (!imem_en)
			@(posedge clk);
		trap   <= do_trap;
		boj    <= do_boj;
		boj_pc <= t;
		@(posedge clk);
		trap <= 1'b0;
		boj  <= 1'b0;
		exp_pc = do_trap ? exp_trap_vec : t;
		exp_redir++;
	endtask

	// Model follows at the falling edge, after the table write
	task automatic train(input fetch_pkg::addr_t a, input logic taken,
		input fetch_pkg::addr_t t);
		@(posedge clk);
		res_valid  <= 1'b1;
		res_pc     <= a;
		res_taken  <= taken;
		res_target <= t;
		@(posedge clk);
		res_valid <= 1'b0;
		@(negedge clk);
		model_update(a, taken, t);
	endtask

	task automatic write_cfg(input fetch_pkg::cfg_addr_t a, input fetch_pkg::addr_t d);
		@(posedge clk);
		cfg_we    <= 1'b1;
		cfg_addr  <= a;
		cfg_wdata <= d;
		@(posedge clk);
		cfg_we <= 1'b0;
		@(negedge clk);
		if (a == fetch_pkg::CFG_CTRL)
			exp_pred_en = d[0];
		else if (a == fetch_pkg::CFG_TRAP_VEC)
			exp_trap_vec = d & ~32'd3;
	endtask

	task automatic read_cfg(input string field, input fetch_pkg::cfg_addr_t a,
		input logic [31:0] exp_v);
		@(posedge clk);
		cfg_addr <= a;
		@(posedge clk);
		check_value(field, exp_v, cfg_rdata);
	endtask

	// Alternating stall runs of random length
	task automatic random_stalls(input int cycles);
		int   left;
		int   run;
		logic level;
		left  = cycles;
		level = 1'b0;
		while (left > 0) begin
			run   = 1 + $urandom_range(5, 0);
			level = !level;
			repeat (run) begin
				@(posedge clk);
				stall <= level;
			end
			left -= run;
		end
		@(posedge clk);
		stall <= 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n      = 1'b1;
		boj        = 1'b0;
		boj_pc     = '0;
		trap       = 1'b0;
		res_valid  = 1'b0;
		res_pc     = '0;
		res_taken  = 1'b0;
		res_target = '0;
		stall      = 1'b0;
		cfg_we     = 1'b0;
		cfg_addr   = '0;
		cfg_wdata  = '0;
		for (int i = 0; i < BP_ENTRIES; i++)
			m_valid[i] = 1'b0;
		exp_pred_en  = 1'b1;
		exp_trap_vec = `TRAP_VEC_RESET;
		exp_pc       = `PC_RESET;
		exp_redir    = 0;
		beat_cnt     = 0;
		test_name    = "reset";

		repeat (RESET_CYCLES) @(posedge clk);
		check_value("imem_en", 32'd0, {31'd0, imem_en});
		check_value("valid", 32'd0, {31'd0, valid});
		check_value("prediction", 32'd0, {31'd0, prediction});
		rst_n <= 1'b0;
		read_cfg("ctrl", fetch_pkg::CFG_CTRL, 32'd1);
		read_cfg("trap_vec", fetch_pkg::CFG_TRAP_VEC, `TRAP_VEC_RESET);
		read_cfg("redir_cnt", fetch_pkg::CFG_REDIR_CNT, 32'd0);

		test_name = "sequential";
		wait_beats(8);

		test_name = "redirect";
		issue_redirect(1'b0, 1'b1, BOJ_PC);
		wait_beats(4);
		read_cfg("redir_cnt", fetch_pkg::CFG_REDIR_CNT, 32'(exp_redir));

		// Train taken, then back off to not taken
		test_name = "predict_taken";
		issue_redirect(1'b0, 1'b1, LOOP_PC);
		train(BR_A, 1'b1, BR_TARGET);
		train(BR_A, 1'b1, BR_TARGET);
		wait_beats(8);
		test_name = "predict_not_taken";
		issue_redirect(1'b0, 1'b1, LOOP_PC);
		train(BR_A, 1'b0, BR_TARGET);
		train(BR_A, 1'b0, BR_TARGET);
		wait_beats(6);

		// Low bits of the written vector are dropped
		test_name = "trap";
		write_cfg(fetch_pkg::CFG_TRAP_VEC, 32'h0000_0302);
		read_cfg("trap_vec", fetch_pkg::CFG_TRAP_VEC, exp_trap_vec);
		issue_redirect(1'b1, 1'b0, BOJ_PC);
		wait_beats(4);
		test_name = "trap_over_redirect";
		issue_redirect(1'b1, 1'b1, BOJ_PC);
		wait_beats(4);
		read_cfg("redir_cnt", fetch_pkg::CFG_REDIR_CNT, 32'(exp_redir));

		test_name = "predict_disabled";
		write_cfg(fetch_pkg::CFG_CTRL, 32'd0);
		read_cfg("ctrl", fetch_pkg::CFG_CTRL, 32'd0);
		issue_redirect(1'b0, 1'b1, LOOP_PC);
		train(BR_A, 1'b1, BR_TARGET);
		train(BR_A, 1'b1, BR_TARGET);
		wait_beats(6);
		write_cfg(fetch_pkg::CFG_CTRL, 32'd1);

		test_name = "stall";
		random_stalls(STALL_CYCLES);
		wait_beats(4);
		read_cfg("redir_cnt", fetch_pkg::CFG_REDIR_CNT, 32'(exp_redir));

		$display("sim passed");
		$finish;
	end

endmodule

// File: verilog/bp_if.sv
/*
 * Branch predictor link
 * Combinational lookup from fetch and the resolve update strobe
 */

interface bp_if;

	// Lookup, PC and returned word of the current response
	fetch_pkg::addr_t  lookup_pc;
	fetch_pkg::instr_t lookup_instr;
	logic              pred_taken;
	fetch_pkg::addr_t  pred_target;

	// Update from execute, single-cycle strobe
	logic              upd_valid;
	fetch_pkg::addr_t  upd_pc;
	logic              upd_taken;
	fetch_pkg::addr_t  upd_target;

	modport fetch (
		output lookup_pc, lookup_instr, upd_valid, upd_pc, upd_taken, upd_target,
		input  pred_taken, pred_target
	);

	modport pred (
		input  lookup_pc, lookup_instr, upd_valid, upd_pc, upd_taken, upd_target,
		output pred_taken, pred_target
	);

endinterface

// File: verilog/branch_predictor.sv
/*
 * Direct-mapped branch predictor
 * Valid, tag, 2-bit counter and target per entry; combinational
 * lookup on B-type words, registered update from execute
 */

`include "fetch_config.svh"

module branch_predictor (
	input logic clk,
	input logic rst_n,
	bp_if.pred  bp
);

	localparam int ENTRIES = 1 << `BP_IDX_W;

	// Table storage
	logic              valid  [ENTRIES];
	fetch_pkg::bp_tag_t tag    [ENTRIES];
	fetch_pkg::ctr_t   ctr    [ENTRIES];
	fetch_pkg::addr_t  target [ENTRIES];

	fetch_pkg::bp_idx_t lk_idx;
	fetch_pkg::bp_tag_t lk_tag;
	logic               lk_branch;
	logic               lk_hit;

	fetch_pkg::bp_idx_t up_idx;
	fetch_pkg::bp_tag_t up_tag;
	logic               up_hit;
	fetch_pkg::ctr_t    up_ctr;

	// Lookup split, word offset dropped
	assign lk_idx    = bp.lookup_pc[`BP_IDX_W+1:2];
	assign lk_tag    = bp.lookup_pc[31:`BP_IDX_W+2];
	assign lk_branch = (bp.lookup_instr[6:0] == `OPC_BRANCH);
	assign lk_hit    = valid[lk_idx] && (tag[lk_idx] == lk_tag);

	// Taken on counter MSB, only for conditional branches
	assign bp.pred_taken  = lk_branch && lk_hit && ctr[lk_idx][1];
	assign bp.pred_target = target[lk_idx];

	// Update side
	assign up_idx = bp.upd_pc[`BP_IDX_W+1:2];
	assign up_tag = bp.upd_pc[31:`BP_IDX_W+2];
	assign up_hit = valid[up_idx] && (tag[up_idx] == up_tag);

	// New counter value
	always_comb begin
		if (!up_hit) begin
			// Fresh entry starts weakly biased toward the outcome
			up_ctr = bp.upd_taken ? 2'd2 : 2'd1;
		end else if (bp.upd_taken) begin
			up_ctr = (ctr[up_idx] == 2'd3) ? 2'd3 : ctr[up_idx] + 2'd1;
		end else begin
			up_ctr = (ctr[up_idx] == 2'd0) ? 2'd0 : ctr[up_idx] - 2'd1;
		end
	end

	// Valid bits cleared by reset
	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < ENTRIES; i++)
				valid[i] <= 1'b0;
		end else if (bp.upd_valid) begin
			valid[up_idx] <= 1'b1;
		end
	end

	// Tag, counter and target
	always_ff @(posedge clk) begin
		if (bp.upd_valid) begin
			tag[up_idx] <= up_tag;
			ctr[up_idx] <= up_ctr;
			// Allocation always stores, a hit refreshes only when taken
			if (!up_hit || bp.upd_taken)
				target[up_idx] <= bp.upd_target;
		end
	end

	// Resolved branches come from execute on word addresses
	a_upd_aligned: assert property (
		@(posedge clk) disable iff (rst_n)
		bp.upd_valid |-> (bp.upd_pc[1:0] == 2'b00)
	);

endmodule

// File: verilog/fetch_cfg.sv
/*
 * Fetch configuration registers
 * CTRL (prediction enable), TRAP_VEC and read-only REDIR_CNT,
 * strobe written with combinational readback
 */

`include "fetch_config.svh"

module fetch_cfg (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_cfg_we,
	input  fetch_pkg::cfg_addr_t  i_cfg_addr,
	input  fetch_pkg::addr_t      i_cfg_wdata,
	input  logic                  i_redirect,
	output fetch_pkg::addr_t      o_cfg_rdata,
	output logic                  o_predict_en,
	output fetch_pkg::addr_t      o_trap_vec
);

	fetch_pkg::cnt_t redir_cnt;

	// CTRL and TRAP_VEC writes, other addresses ignored
	always_ff @(posedge clk) begin
		if (rst_n) begin
			o_predict_en <= 1'b1;
			o_trap_vec   <= `TRAP_VEC_RESET;
		end else if (i_cfg_we) begin
			if (i_cfg_addr == fetch_pkg::CFG_CTRL)
				o_predict_en <= i_cfg_wdata[0];
			// Vector kept word aligned
			if (i_cfg_addr == fetch_pkg::CFG_TRAP_VEC)
				o_trap_vec <= {i_cfg_wdata[31:2], 2'b00};
		end
	end

	// Redirect count, sticks at all ones
	always_ff @(posedge clk) begin
		if (rst_n)
			redir_cnt <= '0;
		else if (i_redirect && (redir_cnt != '1))
			redir_cnt <= redir_cnt + 1'b1;
	end

	// Readback
	always_comb begin
		case (i_cfg_addr)
			fetch_pkg::CFG_CTRL:      o_cfg_rdata = {31'd0, o_predict_en};
			fetch_pkg::CFG_TRAP_VEC:  o_cfg_rdata = o_trap_vec;
			fetch_pkg::CFG_REDIR_CNT: o_cfg_rdata = {16'd0, redir_cnt};
			default:                  o_cfg_rdata = '0;
		endcase
	end

endmodule

// File: verilog/fetch_config.svh
/*
 * Fetch front end constants
 * Reset PC, default trap vector, predictor size and branch opcode
 */

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// First fetch address out of reset
`define PC_RESET 32'h0000_0000

// Trap vector until software writes TRAP_VEC
`define TRAP_VEC_RESET 32'h0000_0100

// Predictor index width, 16 entries
`define BP_IDX_W 4

// RV32 conditional branch (B-type) major opcode
`define OPC_BRANCH 7'b1100011

`endif

// File: verilog/fetch_frontend.sv
/*
 * Fetch front end top level
 * Fetch unit, branch predictor and configuration registers
 */

module fetch_frontend (
	input  logic                 clk,
	input  logic                 rst_n,
	// Instruction memory
	input  logic                 i_imem_rdy,
	output logic                 o_imem_en,
	output fetch_pkg::addr_t     o_iaddr,
	input  logic                 i_imem_vld,
	input  fetch_pkg::instr_t    i_inst,
	// Redirect and trap
	input  logic                 i_boj,
	input  fetch_pkg::addr_t     i_boj_pc,
	input  logic                 i_trap,
	// Branch resolve
	input  logic                 i_res_valid,
	input  fetch_pkg::addr_t     i_res_pc,
	input  logic                 i_res_taken,
	input  fetch_pkg::addr_t     i_res_target,
	input  logic                 i_stall,
	// Configuration port
	input  logic                 i_cfg_we,
	input  fetch_pkg::cfg_addr_t i_cfg_addr,
	input  fetch_pkg::addr_t     i_cfg_wdata,
	output fetch_pkg::addr_t     o_cfg_rdata,
	// To decode
	output logic                 o_valid,
	output fetch_pkg::addr_t     o_pc,
	output fetch_pkg::instr_t    o_instr,
	output logic                 o_prediction
);

	logic             predict_en;
	logic             redirect;
	fetch_pkg::addr_t trap_vec;

	bp_if bp_bus ();

	fetch_unit u_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_imem_rdy   (i_imem_rdy),
		.o_imem_en    (o_imem_en),
		.o_iaddr      (o_iaddr),
		.i_imem_vld   (i_imem_vld),
		.i_inst       (i_inst),
		.i_boj        (i_boj),
		.i_boj_pc     (i_boj_pc),
		.i_trap       (i_trap),
		.i_stall      (i_stall),
		.i_predict_en (predict_en),
		.i_trap_vec   (trap_vec),
		.o_redirect   (redirect),
		.i_res_valid  (i_res_valid),
		.i_res_pc     (i_res_pc),
		.i_res_taken  (i_res_taken),
		.i_res_target (i_res_target),
		.o_valid      (o_valid),
		.o_pc         (o_pc),
		.o_instr      (o_instr),
		.o_prediction (o_prediction),
		.bp           (bp_bus.fetch)
	);

	branch_predictor u_bp (
		.clk   (clk),
		.rst_n (rst_n),
		.bp    (bp_bus.pred)
	);

	fetch_cfg u_cfg (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_cfg_we     (i_cfg_we),
		.i_cfg_addr   (i_cfg_addr),
		.i_cfg_wdata  (i_cfg_wdata),
		.i_redirect   (redirect),
		.o_cfg_rdata  (o_cfg_rdata),
		.o_predict_en (predict_en),
		.o_trap_vec   (trap_vec)
	);

endmodule

// File: verilog/fetch_pkg.sv
/*
 * Fetch front end types
 * Address and word vectors, predictor fields, FSM states and
 * configuration register addresses
 */

`include "fetch_config.svh"

package fetch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] instr_t;

	// Predictor index and tag split of the PC above bit 1
	typedef logic [`BP_IDX_W-1:0] bp_idx_t;
	typedef logic [29-`BP_IDX_W:0] bp_tag_t;

	// 2-bit saturating counter, taken when 2 or more
	typedef logic [1:0] ctr_t;

	// Redirect event count
	typedef logic [15:0] cnt_t;

	// Fetch FSM, one request outstanding at most
	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		DROP
	} fetch_state_t;

	// Configuration register map
	typedef logic [1:0] cfg_addr_t;
	localparam cfg_addr_t CFG_CTRL      = 2'd0;
	localparam cfg_addr_t CFG_TRAP_VEC  = 2'd1;
	localparam cfg_addr_t CFG_REDIR_CNT = 2'd2;

endpackage

// File: verilog/fetch_unit.sv
/*
 * Instruction fetch unit
 * PC register, next-PC priority (trap, redirect, prediction, pc+4),
 * single outstanding memory request and delivery staging to decode
 */

`include "fetch_config.svh"

module fetch_unit (
	input  logic              clk,
	input  logic              rst_n,
	// Instruction memory
	input  logic              i_imem_rdy,
	output logic              o_imem_en,
	output fetch_pkg::addr_t  o_iaddr,
	input  logic              i_imem_vld,
	input  fetch_pkg::instr_t i_inst,
	// Redirects
	input  logic              i_boj,
	input  fetch_pkg::addr_t  i_boj_pc,
	input  logic              i_trap,
	input  logic              i_stall,
	// Configuration
	input  logic              i_predict_en,
	input  fetch_pkg::addr_t  i_trap_vec,
	output logic              o_redirect,
	// Branch resolve, routed on to the predictor
	input  logic              i_res_valid,
	input  fetch_pkg::addr_t  i_res_pc,
	input  logic              i_res_taken,
	input  fetch_pkg::addr_t  i_res_target,
	// Decode
	output logic              o_valid,
	output fetch_pkg::addr_t  o_pc,
	output fetch_pkg::instr_t o_instr,
	output logic              o_prediction,
	bp_if.fetch               bp
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::fetch_state_t state_next;
	fetch_pkg::addr_t        pc;
	fetch_pkg::addr_t        pc_next;
	fetch_pkg::addr_t        redir_pc;
	logic                    redir_evt;
	logic                    deliver;
	logic                    take_pred;

	// Trap beats redirect
	assign redir_evt = i_trap | i_boj;
	assign redir_pc  = i_trap ? i_trap_vec : i_boj_pc;
	assign o_redirect = redir_evt;

	// Good response, not killed by a same-cycle redirect
	assign deliver = (state == fetch_pkg::WAIT) && i_imem_vld && !redir_evt;

	// PC holds the outstanding address while waiting
	assign bp.lookup_pc    = pc;
	assign bp.lookup_instr = i_inst;
	assign take_pred       = i_predict_en && bp.pred_taken;

	// Resolve pass-through
	assign bp.upd_valid  = i_res_valid;
	assign bp.upd_pc     = i_res_pc;
	assign bp.upd_taken  = i_res_taken;
	assign bp.upd_target = i_res_target;

	// Request only from IDLE out of reset; a redirect this cycle retargets first
	assign o_imem_en = !rst_n && (state == fetch_pkg::IDLE) && i_imem_rdy
		&& !i_stall && !redir_evt;
	assign o_iaddr   = pc;

	// Next PC
	always_comb begin
		pc_next = pc;
		if (redir_evt)
			pc_next = redir_pc;
		else if (deliver)
			pc_next = take_pred ? bp.pred_target : pc + 32'd4;
	end

	// FSM
	always_comb begin
		state_next = state;
		case (state)
			fetch_pkg::IDLE: begin
				if (o_imem_en)
					state_next = fetch_pkg::WAIT;
			end
			fetch_pkg::WAIT: begin
				if (i_imem_vld)
					state_next = fetch_pkg::IDLE;
				else if (redir_evt)
					state_next = fetch_pkg::DROP;
			end
			fetch_pkg::DROP: begin
				// Stale response swallowed
				if (i_imem_vld)
					state_next = fetch_pkg::IDLE;
			end
			default: state_next = fetch_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state <= fetch_pkg::IDLE;
			pc    <= `PC_RESET;
		end else begin
			state <= state_next;
			pc    <= pc_next;
		end
	end

	// Delivery strobe and prediction bit
	always_ff @(posedge clk) begin
		if (rst_n) begin
			o_valid      <= 1'b0;
			o_prediction <= 1'b0;
		end else begin
			o_valid <= deliver;
			if (deliver)
				o_prediction <= take_pred;
		end
	end

	// Payload, qualified by o_valid
	always_ff @(posedge clk) begin
		if (deliver) begin
			o_pc    <= pc;
			o_instr <= i_inst;
		end
	end

	// Memory answers only an outstanding request
	a_no_vld_idle: assert property (
		@(posedge clk) disable iff (rst_n)
		i_imem_vld |-> (state != fetch_pkg::IDLE)
	);

	// No new request until the outstanding one is answered
	a_one_req: assert property (
		@(posedge clk) disable iff (rst_n)
		(state != fetch_pkg::IDLE) && !i_imem_vld |=> !o_imem_en
	);

endmodule
